// File: dv/l2_cases.txt
// Columns: port op(1 write, 0 read) address byte_enables write_data expected_read_data
// Expected data is only compared for reads
0 1 1C000000 F 11111111 00000000
1 1 1C000004 F 22222222 00000000
2 1 1C000008 F 33333333 00000000
3 1 1C00000C F 44444444 00000000
4 1 1C000010 F 55555555 00000000
5 1 1C000FFC F A5A5A5A5 00000000
0 0 1C000000 F 00000000 11111111
1 0 1C000004 F 00000000 22222222
2 0 1C000008 F 00000000 33333333
3 0 1C00000C F 00000000 44444444
4 0 1C000010 F 00000000 55555555
5 0 1C000FFC F 00000000 A5A5A5A5
0 1 1C000000 1 000000AA 00000000
1 1 1C000000 4 00BB0000 00000000
2 0 1C000000 F 00000000 11BB11AA
3 1 1C000004 C DEAD0000 00000000
4 0 1C000004 F 00000000 DEAD2222
5 1 1C000008 3 0000BEEF 00000000
0 0 1C000008 F 00000000 3333BEEF
1 1 1C00000C 8 CC000000 00000000
2 1 1C00000C 2 0000DD00 00000000
3 0 1C00000C F 00000000 CC44DD44
4 1 1C000010 0 FFFFFFFF 00000000
5 0 1C000010 F 00000000 55555555
0 1 1C000400 F 01234567 00000000
1 0 1C000400 F 00000000 01234567
2 1 1C000400 6 89ABCDEF 00000000
3 0 1C000400 F 00000000 01ABCD67
4 0 1C000FFC F 00000000 A5A5A5A5
5 0 1C000000 F 00000000 11BB11AA
0 1 1C000FF0 F 5A5A0F0F 00000000
1 0 1C000FF0 F 00000000 5A5A0F0F

// File: dv/l2_checker.sv
// L2 port checker
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_checker (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  l2_bus_pkg::l2_req_t [`L2_NUM_PORTS-1:0] port_req_i,
  input  l2_bus_pkg::l2_rsp_t [`L2_NUM_PORTS-1:0] port_rsp_i,
  input  logic                                    case_chk_i,  // Read with file-given data
  input  l2_mem_pkg::port_idx_t                   case_port_i,
  input  logic [`L2_DATA_WIDTH-1:0]               case_exp_i,
  output int                                      data_err_o,
  output int                                      proto_err_o
);

  import l2_mem_pkg::*;

  localparam int NP    = `L2_NUM_PORTS;
  localparam int NB    = `L2_NUM_BANKS;
  localparam int DW    = `L2_DATA_WIDTH;
  localparam int BW    = `L2_DATA_WIDTH / 8;
  localparam int WORDS = `L2_NUM_BANKS * `L2_BANK_WORDS;

  // Reference memory, indexed by word offset from the L2 base
  logic [DW-1:0] ref_mem   [WORDS];
  logic [BW-1:0] ref_known [WORDS]; // Bytes written at least once

  // Per-port response expected at the next edge
  logic          pend_q      [NP];
  logic          pend_rd_q   [NP];
  logic [DW-1:0] pend_data_q [NP];
  logic [BW-1:0] pend_mask_q [NP];
  logic          pend_case_q [NP];
  logic [DW-1:0] pend_exp_q  [NP];
  int            wait_q      [NP]; // Cycles spent waiting for gnt

  function automatic int word_of(logic [`L2_ADDR_WIDTH-1:0] addr);
    logic [`L2_ADDR_WIDTH-1:0] off;
    off = addr - `L2_BASE_ADDR;
    return int'(off[`L2_ADDR_WIDTH-1:2]) % WORDS;
  endfunction

  function automatic logic [DW-1:0] byte_mask(logic [BW-1:0] be);
    logic [DW-1:0] m;
    for (int i = 0; i < BW; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  always @(posedge clk_i) begin
    int            w;
    int            nreq;
    int            ngnt;
    logic [DW-1:0] m;
    if (!rst_n_i) begin
      for (int p = 0; p < NP; p++) begin
        pend_q[p]      = 1'b0;
        pend_rd_q[p]   = 1'b0;
        pend_case_q[p] = 1'b0;
        wait_q[p]      = 0;
      end
      for (int i = 0; i < WORDS; i++) begin
        ref_known[i] = '0;
      end
      data_err_o  = 0;
      proto_err_o = 0;
    end else begin
      // Responses due for takes one cycle ago
      for (int p = 0; p < NP; p++) begin
        if (port_rsp_i[p].r_valid !== pend_q[p]) begin
          $display("CHECK FAILED t=%0t port_rsp_o[%0d].r_valid expected %0b actual %0b",
                   $time, p, pend_q[p], port_rsp_i[p].r_valid);
          proto_err_o++;
        end else if (pend_q[p] && pend_rd_q[p]) begin
          m = byte_mask(pend_mask_q[p]); // Never-written bytes are undefined
          if ((port_rsp_i[p].r_rdata & m) !== (pend_data_q[p] & m)) begin
            $display("CHECK FAILED t=%0t port_rsp_o[%0d].r_rdata expected %h actual %h",
                     $time, p, pend_data_q[p] & m, port_rsp_i[p].r_rdata & m);
            data_err_o++;
          end
          if (pend_case_q[p] && port_rsp_i[p].r_rdata !== pend_exp_q[p]) begin
            $display("CHECK FAILED t=%0t port_rsp_o[%0d].r_rdata expected %h actual %h",
                     $time, p, pend_exp_q[p], port_rsp_i[p].r_rdata);
            data_err_o++;
          end
        end
      end

      // One grant per contended bank, none without a request
      for (int b = 0; b < NB; b++) begin
        nreq = 0;
        ngnt = 0;
        for (int p = 0; p < NP; p++) begin
          if (port_req_i[p].req && (word_of(port_req_i[p].addr) % NB) == b) begin
            nreq++;
            if (port_rsp_i[p].gnt) ngnt++;
          end
        end
        if (nreq > 0 && ngnt != 1) begin
          $display("At t=%0t bank %0d had %0d requesting ports but %0d grants",
                   $time, b, nreq, ngnt);
          proto_err_o++;
        end
      end

      for (int p = 0; p < NP; p++) begin
        if (!port_req_i[p].req && port_rsp_i[p].gnt) begin
          $display("CHECK FAILED t=%0t port_rsp_o[%0d].gnt expected 0 actual 1", $time, p);
          proto_err_o++;
        end
        if (port_req_i[p].req && !port_rsp_i[p].gnt) begin
          wait_q[p]++;
          if (wait_q[p] == NP) begin
            $display("At t=%0t port %0d has waited %0d cycles without a grant",
                     $time, p, wait_q[p]);
            proto_err_o++;
          end
        end else begin
          wait_q[p] = 0;
        end

        // Takes at this edge update the model in grant order
        pend_q[p]      = port_req_i[p].req && port_rsp_i[p].gnt;
        pend_rd_q[p]   = 1'b0;
        pend_case_q[p] = 1'b0;
        if (pend_q[p]) begin
          w = word_of(port_req_i[p].addr);
          if (port_req_i[p].wen) begin
            pend_rd_q[p]   = 1'b1;
            pend_data_q[p] = ref_mem[w];
            pend_mask_q[p] = ref_known[w];
            pend_case_q[p] = case_chk_i && (case_port_i == port_idx_t'(p));
            pend_exp_q[p]  = case_exp_i;
          end else begin
            for (int i = 0; i < BW; i++) begin
              if (port_req_i[p].be[i]) ref_mem[w][8*i +: 8] = port_req_i[p].wdata[8*i +: 8];
            end
            ref_known[w] = ref_known[w] | port_req_i[p].be;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/l2_subsystem_tb.sv
// L2 scratchpad testbench
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_subsystem_tb;

  import l2_bus_pkg::*;
  import l2_mem_pkg::*;

  localparam int NP        = `L2_NUM_PORTS;
  localparam int MAX_CASES = 64;
  localparam int CASE_COLS = 6; // port, op, addr, be, wdata, expected
  localparam int RAND_REQS = 200;

  logic                     clk;
  logic                     rst_n;
  l2_req_t [NP-1:0]         port_req;
  l2_rsp_t [NP-1:0]         port_rsp;
  logic                     case_chk;
  port_idx_t                case_port;
  logic [`L2_DATA_WIDTH-1:0] case_exp;
  int                       data_errs;
  int                       proto_errs;

  logic [31:0] case_mem [MAX_CASES*CASE_COLS];
  int          num_cases;
  int          cycle_cnt;
  int          cycle_limit;
  logic [15:0] lfsr;
  l2_req_t     cur_req [NP]; // Request each port is presenting

  l2_subsystem UUT (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .port_req_i ( port_req ),
    .port_rsp_o ( port_rsp )
  );

  l2_checker i_checker (
    .clk_i       ( clk        ),
    .rst_n_i     ( rst_n      ),
    .port_req_i  ( port_req   ),
    .port_rsp_i  ( port_rsp   ),
    .case_chk_i  ( case_chk   ),
    .case_port_i ( case_port  ),
    .case_exp_i  ( case_exp   ),
    .data_err_o  ( data_errs  ),
    .proto_err_o ( proto_errs )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, traffic did not complete", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // One step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // One directed case held until granted
  task automatic issue_case(int idx);
    int p;
    p = int'(case_mem[idx*CASE_COLS]);
    cur_req[p].req   = 1'b1;
    cur_req[p].wen   = (case_mem[idx*CASE_COLS+1] == 32'd0); // Op 0 is a read
    cur_req[p].addr  = case_mem[idx*CASE_COLS+2];
    cur_req[p].be    = case_mem[idx*CASE_COLS+3][3:0];
    cur_req[p].wdata = case_mem[idx*CASE_COLS+4];
    port_req[p] <= cur_req[p];
    case_chk    <= cur_req[p].wen;
    case_port   <= port_idx_t'(p);
    case_exp    <= case_mem[idx*CASE_COLS+5];
    do @(posedge clk); while (!port_rsp[p].gnt);
    cur_req[p].req = 1'b0;
    port_req[p] <= cur_req[p];
    case_chk    <= 1'b0;
  endtask

  // Ports launch at random and contend for banks
  task automatic drive_random();
    int          issued;
    int          busy;
    logic [31:0] r;
    issued = 0;
    busy   = 0;
    while (issued < RAND_REQS || busy != 0) begin
      @(posedge clk);
      for (int p = 0; p < NP; p++) begin
        if (cur_req[p].req && port_rsp[p].gnt) begin
          cur_req[p].req = 1'b0;
          busy--;
        end
        r = rand_bits(1);
        if (!cur_req[p].req && issued < RAND_REQS && r[0]) begin
          cur_req[p].req = 1'b1;
          r = rand_bits(1);
          cur_req[p].wen = r[0];
          r = rand_bits(6);  // 64-word window keeps conflicts frequent
          cur_req[p].addr = `L2_BASE_ADDR + {r[29:0], 2'b00};
          r = rand_bits(4);
          cur_req[p].be    = r[3:0];
          cur_req[p].wdata = rand_bits(32);
          issued++;
          busy++;
        end
        port_req[p] <= cur_req[p];
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    case_chk  = 1'b0;
    case_port = '0;
    case_exp  = '0;
    port_req  = '0;
    cycle_cnt = 0;
    lfsr      = 16'd35;
    for (int p = 0; p < NP; p++) begin
      cur_req[p] = '0;
    end
    for (int i = 0; i < MAX_CASES*CASE_COLS; i++) begin
      case_mem[i] = '1; // End marker for unused entries
    end
    $readmemh("dv/l2_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases*CASE_COLS] != '1) num_cases++;
    cycle_limit = (num_cases + RAND_REQS) * (NP + 2) + 100;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk); // No gnt or r_valid expected while ports idle

    for (int i = 0; i < num_cases; i++) begin
      issue_case(i);
    end
    drive_random();
    repeat (3) @(posedge clk);
    @(negedge clk); // Checker has settled the last edge

    $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs + proto_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/l2_bus_pkg.sv
source/l2_mem_pkg.sv
source/l2_req_xbar.sv
source/l2_bank.sv
source/l2_resp_router.sv
source/l2_subsystem.sv
dv/l2_checker.sv
dv/l2_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the L2 scratchpad simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module l2_subsystem_tb -o l2_sim

out=$(./obj_dir/l2_sim)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
  exit 0
else
  exit 1
fi

// File: source/l2_bank.sv
// L2 SRAM bank
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_bank (
  input  logic                      clk_i,
  input  l2_mem_pkg::bank_req_t     bank_req_i,
  output logic [`L2_DATA_WIDTH-1:0] rdata_o
);

  localparam int unsigned BYTES = `L2_DATA_WIDTH / 8;

  // Single-port array, contents undefined after power-up
  logic [`L2_DATA_WIDTH-1:0] mem_q [`L2_BANK_WORDS];

  // Byte-enable write
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && bank_req_i.we) begin
      for (int i = 0; i < BYTES; i++) begin
        if (bank_req_i.be[i]) begin
          mem_q[bank_req_i.row][8*i +: 8] <= bank_req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // Read data registered, visible the cycle after the request
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req && !bank_req_i.we) begin
      rdata_o <= mem_q[bank_req_i.row];
    end
  end

endmodule

`default_nettype wire

// File: source/l2_bus_pkg.sv
// L2 port-side bus types
`default_nettype none

`include "l2_settings.svh"

package l2_bus_pkg;

  // One TCDM-style request from a requester port
  typedef struct packed {
    logic                         req;   // Held until gnt
    logic [`L2_ADDR_WIDTH-1:0]    addr;  // Absolute address, L2 base included
    logic                         wen;   // Low for a write
    logic [`L2_DATA_WIDTH/8-1:0]  be;    // Byte enables
    logic [`L2_DATA_WIDTH-1:0]    wdata;
  } l2_req_t;

  // Response back to the same port
  typedef struct packed {
    logic                         gnt;     // Request taken this cycle
    logic                         r_valid; // One cycle after the take
    logic [`L2_DATA_WIDTH-1:0]    r_rdata; // Only meaningful for reads
  } l2_rsp_t;

endpackage

`default_nettype wire

// File: source/l2_mem_pkg.sv
// L2 bank-side types
`default_nettype none

`include "l2_settings.svh"

package l2_mem_pkg;

  typedef logic [$clog2(`L2_NUM_PORTS)-1:0] port_idx_t; // Requester port number
  typedef logic [`L2_BANK_SEL_W-1:0]        bank_idx_t; // Bank number from the word address
  typedef logic [`L2_ROW_W-1:0]             row_t;      // Word row inside one bank

  // Request seen by one SRAM bank
  typedef struct packed {
    logic                         req;
    logic                         we;   // High for a write
    row_t                         row;
    logic [`L2_DATA_WIDTH/8-1:0]  be;
    logic [`L2_DATA_WIDTH-1:0]    wdata;
  } bank_req_t;

  // Which port won a bank this cycle
  typedef struct packed {
    logic      valid;
    port_idx_t port;
  } bank_grant_t;

endpackage

`default_nettype wire

// File: source/l2_req_xbar.sv
// L2 request crossbar
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_req_xbar (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  l2_bus_pkg::l2_req_t   [`L2_NUM_PORTS-1:0]   port_req_i,
  output logic                  [`L2_NUM_PORTS-1:0]   port_gnt_o,
  output l2_mem_pkg::bank_req_t [`L2_NUM_BANKS-1:0]   bank_req_o,
  output l2_mem_pkg::bank_grant_t [`L2_NUM_BANKS-1:0] bank_grant_o
);

  import l2_mem_pkg::*;

  localparam int unsigned NP = `L2_NUM_PORTS;
  localparam int unsigned NB = `L2_NUM_BANKS;

  logic      [NP-1:0][`L2_ADDR_WIDTH-1:0] port_offset; // Address relative to L2 base
  bank_idx_t [NP-1:0]                     port_bank;
  row_t      [NP-1:0]                     port_row;
  logic      [NB-1:0][NP-1:0]             bank_hit;    // Port p requests bank b

  port_idx_t [NB-1:0] rr_ptr_q;  // Last winner per bank
  logic      [NB-1:0] win_valid;
  port_idx_t [NB-1:0] win_port;

  // Port reached after stepping forward from base, wrapping at NP
  function automatic port_idx_t next_port(port_idx_t base, int step);
    int sum;
    sum = int'(base) + step;
    return port_idx_t'(sum % NP);
  endfunction

  // Base removal and bank/row decode
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      port_offset[p] = port_req_i[p].addr - `L2_BASE_ADDR;
      port_bank[p]   = port_offset[p][2 +: `L2_BANK_SEL_W];           // Word interleave
      port_row[p]    = port_offset[p][2 + `L2_BANK_SEL_W +: `L2_ROW_W];
    end
  end

  always_comb begin
    for (int b = 0; b < NB; b++) begin
      for (int p = 0; p < NP; p++) begin
        bank_hit[b][p] = port_req_i[p].req && (port_bank[p] == bank_idx_t'(b));
      end
    end
  end

  // Round-robin pick, search starts one past the previous winner
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      win_valid[b] = 1'b0;
      win_port[b]  = '0;
      for (int k = 1; k <= NP; k++) begin
        if (!win_valid[b] && bank_hit[b][next_port(rr_ptr_q[b], k)]) begin
          win_valid[b] = 1'b1;
          win_port[b]  = next_port(rr_ptr_q[b], k);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else begin
      for (int b = 0; b < NB; b++) begin
        if (win_valid[b]) rr_ptr_q[b] <= win_port[b]; // Idle banks keep their pointer
      end
    end
  end

  // Bank requests take the winner's fields
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      bank_req_o[b].req   = win_valid[b];
      bank_req_o[b].we    = ~port_req_i[win_port[b]].wen;
      bank_req_o[b].row   = port_row[win_port[b]];
      bank_req_o[b].be    = port_req_i[win_port[b]].be;
      bank_req_o[b].wdata = port_req_i[win_port[b]].wdata;

      bank_grant_o[b].valid = win_valid[b];
      bank_grant_o[b].port  = win_port[b];
    end
  end

  // A port decodes to one bank only, so one grant source at most
  always_comb begin
    port_gnt_o = '0;
    for (int b = 0; b < NB; b++) begin
      if (win_valid[b]) port_gnt_o[win_port[b]] = 1'b1;
    end
  end

  for (genvar b = 0; b < NB; b++) begin : bank_chk_gen
    // Never two grants into one bank
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(port_gnt_o & bank_hit[b]));
  end

  for (genvar p = 0; p < NP; p++) begin : port_chk_gen
    // Grant must be backed by the decoded bank's request and bookkeeping
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      port_gnt_o[p] |-> (bank_req_o[port_bank[p]].req &&
                         bank_grant_o[port_bank[p]].port == port_idx_t'(p)));
  end

endmodule

`default_nettype wire

// File: source/l2_resp_router.sv
// L2 response router
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_resp_router (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  l2_mem_pkg::bank_grant_t [`L2_NUM_BANKS-1:0]   bank_grant_i,
  input  logic                    [`L2_NUM_PORTS-1:0]   port_gnt_i,
  input  logic [`L2_NUM_BANKS-1:0][`L2_DATA_WIDTH-1:0]  bank_rdata_i,
  output l2_bus_pkg::l2_rsp_t     [`L2_NUM_PORTS-1:0]   port_rsp_o
);

  import l2_mem_pkg::*;

  localparam int unsigned NP = `L2_NUM_PORTS;
  localparam int unsigned NB = `L2_NUM_BANKS;

  bank_grant_t [NB-1:0]         grant_q; // Winner of each bank, one cycle old
  logic        [NP-1:0][NB-1:0] rsp_hit; // Bank b answers port p this cycle

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      grant_q <= '0;
    end else begin
      grant_q <= bank_grant_i; // Reloaded every cycle, one response per bank in flight
    end
  end

  always_comb begin
    for (int p = 0; p < NP; p++) begin
      for (int b = 0; b < NB; b++) begin
        rsp_hit[p][b] = grant_q[b].valid && (grant_q[b].port == port_idx_t'(p));
      end
    end
  end

  // Steer bank read data back, write responses reuse the same path
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      port_rsp_o[p].gnt     = port_gnt_i[p];
      port_rsp_o[p].r_valid = |rsp_hit[p];
      port_rsp_o[p].r_rdata = '0;
      for (int b = 0; b < NB; b++) begin
        if (rsp_hit[p][b]) port_rsp_o[p].r_rdata = bank_rdata_i[b];
      end
    end
  end

  for (genvar p = 0; p < NP; p++) begin : rsp_chk_gen
    // Crossbar grants a port into one bank per cycle only
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(rsp_hit[p]));
  end

endmodule

`default_nettype wire

// File: source/l2_settings.svh
// L2 scratchpad sizing
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// Requester ports, four AXI bridge ports then two uDMA channels
`define L2_NUM_PORTS  6

// Word-interleaved banks
`define L2_NUM_BANKS  4
`define L2_BANK_WORDS 256 // 32-bit words per bank

`define L2_DATA_WIDTH 32
`define L2_ADDR_WIDTH 32
`define L2_BASE_ADDR  32'h1C00_0000 // Start of the L2 region

`define L2_BANK_SEL_W 2 // log2 of the bank count
`define L2_ROW_W      8 // log2 of the bank depth

`endif

// File: source/l2_subsystem.sv
// L2 scratchpad top level
`timescale 1ns/1ps
`default_nettype none

`include "l2_settings.svh"

module l2_subsystem (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  l2_bus_pkg::l2_req_t [`L2_NUM_PORTS-1:0]  port_req_i, // Ports 0-3 AXI bridge, 4-5 uDMA
  output l2_bus_pkg::l2_rsp_t [`L2_NUM_PORTS-1:0]  port_rsp_o
);

  import l2_mem_pkg::*;

  bank_req_t   [`L2_NUM_BANKS-1:0]                     bank_req;
  bank_grant_t [`L2_NUM_BANKS-1:0]                     bank_grant;
  logic        [`L2_NUM_BANKS-1:0][`L2_DATA_WIDTH-1:0] bank_rdata;
  logic        [`L2_NUM_PORTS-1:0]                     port_gnt;

  l2_req_xbar i_req_xbar (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .port_req_i   ( port_req_i ),
    .port_gnt_o   ( port_gnt   ),
    .bank_req_o   ( bank_req   ),
    .bank_grant_o ( bank_grant )
  );

  // One SRAM cut per interleaved bank
  for (genvar b = 0; b < `L2_NUM_BANKS; b++) begin : banks_gen
    l2_bank i_bank (
      .clk_i      ( clk_i         ),
      .bank_req_i ( bank_req[b]   ),
      .rdata_o    ( bank_rdata[b] )
    );
  end

  l2_resp_router i_resp_router (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .bank_grant_i ( bank_grant ),
    .port_gnt_i   ( port_gnt   ),
    .bank_rdata_i ( bank_rdata ),
    .port_rsp_o   ( port_rsp_o )
  );

endmodule

`default_nettype wire
